/* flist.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/request_buffer.sv
hdl/port_arbiter.sv
hdl/ram.sv
hdl/mem_subsystem.sv
verification/mem_subsystem_properties.sv
verification/mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/request_buffer.sv
      - hdl/port_arbiter.sv
      - hdl/ram.sv
      - hdl/mem_subsystem.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/mem_subsystem_properties.sv
      - verification/mem_subsystem_tb.sv

/* verification/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int timeout_cycles = 40;

    logic       clock;
    logic       rst;
    logic       fetch_valid;
    logic       fetch_ready;
    fetch_req_t fetch_req;
    logic       fetch_rsp_valid;
    mem_rsp_t   fetch_rsp;
    logic       data_valid;
    logic       data_ready;
    data_req_t  data_req;
    logic       data_rsp_valid;
    mem_rsp_t   data_rsp;

    logic [31:0] model [`MEM_DEPTH_WORDS];  // reference memory.
    logic [31:0] rng_state = 32'h3a0d_44c5;
    int          fetch_outstanding = 0;
    int          data_outstanding = 0;

    bind port_arbiter mem_subsystem_properties arbiter_props (
        .clock           (clock),
        .rst             (rst),
        .ram_valid       (ram_valid),
        .fetch_full      (fetch_full),
        .data_full       (data_full),
        .fetch_rsp_valid (fetch_rsp_valid),
        .data_rsp_valid  (data_rsp_valid)
    );

    mem_subsystem dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ========================================
    // helpers
    // ========================================

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  wstrb);
        logic [31:0] mask;
        mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    function automatic data_req_t random_req(input logic [31:0] mask,
                                             input logic [31:0] base,
                                             input bit          write_ok);
        data_req_t req;
        req.addr  = (next_rand() & mask) | base;
        req.wdata = next_rand();
        req.wstrb = write_ok ? 4'(next_rand()) : 4'h0;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_problem(input string what);
        $display("%0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // one request on one port, then its response.
    task automatic run_access(input port_sel_t port, input data_req_t req,
                              input bit check_rsp, input bit check_latency);
        logic                       is_data;
        logic [`MEM_INDEX_BITS-1:0] idx;
        logic [31:0]                expected;
        int                         cycles;
        is_data  = (port == data_port);
        idx      = req.addr[`MEM_INDEX_BITS+1:2];  // low two bits ignored.
        expected = model[idx];
        @(posedge clock);
        if (is_data) begin
            data_valid <= 1'b1;
            data_req   <= req;
        end else begin
            fetch_valid <= 1'b1;
            fetch_req   <= '{addr: req.addr};
        end
        cycles = 0;
        @(negedge clock);
        while (!(is_data ? data_ready : fetch_ready)) begin
            if (cycles == timeout_cycles) report_problem("request was never accepted");
            cycles++;
            @(negedge clock);
        end
        @(posedge clock);  // transfer on this edge.
        if (is_data) data_valid <= 1'b0;
        else fetch_valid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            check_value(is_data ? "data_ready" : "fetch_ready",
                        is_data ? data_ready : fetch_ready, 0);
            if (cycles > timeout_cycles) report_problem("response never arrived");
        end while (!(is_data ? data_rsp_valid : fetch_rsp_valid));
        if (check_latency) check_value("response latency", cycles, 3);
        if (check_rsp) begin
            check_value(is_data ? "data_rsp" : "fetch_rsp",
                        is_data ? data_rsp.rdata : fetch_rsp.rdata, expected);
        end
        if (is_data) model[idx] = merge_bytes(expected, req.wdata, req.wstrb);
    endtask

    // every response must match one accepted request.
    always @(posedge clock) begin
        if (dut.arbiter.arbiter_props.failure_count != 0) begin
            report_problem("an arbiter assertion failed");
        end
        if (fetch_rsp_valid && fetch_outstanding == 0) report_problem("stray fetch response");
        if (data_rsp_valid && data_outstanding == 0) report_problem("stray data response");
        fetch_outstanding = fetch_outstanding + int'(fetch_valid && fetch_ready)
                            - int'(fetch_rsp_valid);
        data_outstanding = data_outstanding + int'(data_valid && data_ready)
                           - int'(data_rsp_valid);
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin
        data_req_t req;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        data_valid  = 1'b0;
        data_req    = '0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clock);
            check_value("fetch_ready", fetch_ready, 1);
            check_value("data_ready", data_ready, 1);
            check_value("fetch_rsp_valid", fetch_rsp_valid, 0);
            check_value("data_rsp_valid", data_rsp_valid, 0);
        end
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            req = '{addr: 32'(i * 4), wdata: next_rand(), wstrb: 4'hf};
            run_access(data_port, req, 1'b0, 1'b0);
        end
        run_access(data_port, random_req(32'h3ff, 32'h0, 1'b1), 1'b1, 1'b1);
        run_access(fetch_port, random_req(32'h3ff, 32'h0, 1'b0), 1'b1, 1'b1);
        repeat (200) run_access(data_port, random_req(32'h3ff, 32'h0, 1'b1), 1'b1, 1'b0);
        repeat (100) run_access(fetch_port, random_req(32'h3ff, 32'h0, 1'b0), 1'b1, 1'b0);
        // data in the upper half, fetch in the lower half.
        fork
            repeat (80) run_access(data_port, random_req(32'h1ff, 32'h200, 1'b1), 1'b1, 1'b0);
            repeat (80) run_access(fetch_port, random_req(32'h1ff, 32'h0, 1'b0), 1'b1, 1'b0);
        join
        repeat (2) @(negedge clock);
        check_value("fetch_outstanding", fetch_outstanding, 0);
        check_value("data_outstanding", data_outstanding, 0);
        if (dut.arbiter.arbiter_props.failure_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("arbiter assertions failed %0d times",
                     dut.arbiter.arbiter_props.failure_count);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* verification/mem_subsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_properties (
    input wire logic clock,
    input wire logic rst,
    input wire logic ram_valid,
    input wire logic fetch_full,
    input wire logic data_full,
    input wire logic fetch_rsp_valid,
    input wire logic data_rsp_valid
);

    int failure_count = 0;

    // the response cycle still counts as in flight.
    issue_only_when_idle: assert property (@(posedge clock) disable iff (rst)
        ram_valid |=> !ram_valid)
        else begin
            failure_count++;
            $error("ram_valid raised while an access was in flight");
        end

    // only a port that still holds its request may get a response.
    response_to_waiting_port: assert property (@(posedge clock) disable iff (rst)
        !(fetch_rsp_valid && !fetch_full) && !(data_rsp_valid && !data_full))
        else begin
            failure_count++;
            $error("response valid on a port with an empty buffer");
        end

    response_follows_ram_access: assert property (@(posedge clock) disable iff (rst)
        (fetch_rsp_valid || data_rsp_valid) |-> $past(ram_valid))
        else begin
            failure_count++;
            $error("response valid without a RAM access one cycle before");
        end

endmodule

`default_nettype wire

/* hdl/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsystem
    import mem_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst,

    // instruction fetch port.
    input  wire logic       fetch_valid,
    output logic            fetch_ready,
    input  wire fetch_req_t fetch_req,
    output logic            fetch_rsp_valid,
    output mem_rsp_t        fetch_rsp,

    // data port.
    input  wire logic       data_valid,
    output logic            data_ready,
    input  wire data_req_t  data_req,
    output logic            data_rsp_valid,
    output mem_rsp_t        data_rsp
);

    logic        fetch_full;
    logic        fetch_pop;
    fetch_req_t  fetch_held;
    logic        data_full;
    logic        data_pop;
    data_req_t   data_held;
    logic        ram_valid;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [3:0]  ram_wstrb;
    logic        ram_ready;
    mem_rsp_t    ram_rdata;
    mem_rsp_t    rsp;

    request_buffer #(.payload_t(fetch_req_t)) fetch_buffer (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (fetch_valid),
        .in_ready   (fetch_ready),
        .in_payload (fetch_req),
        .full       (fetch_full),
        .payload    (fetch_held),
        .pop        (fetch_pop)
    );

    request_buffer #(.payload_t(data_req_t)) data_buffer (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (data_valid),
        .in_ready   (data_ready),
        .in_payload (data_req),
        .full       (data_full),
        .payload    (data_held),
        .pop        (data_pop)
    );

    port_arbiter arbiter (
        .clock           (clock),
        .rst             (rst),
        .fetch_full      (fetch_full),
        .fetch_req       (fetch_held),
        .fetch_pop       (fetch_pop),
        .data_full       (data_full),
        .data_req        (data_held),
        .data_pop        (data_pop),
        .ram_valid       (ram_valid),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_wstrb       (ram_wstrb),
        .ram_ready       (ram_ready),
        .ram_rdata       (ram_rdata),
        .fetch_rsp_valid (fetch_rsp_valid),
        .data_rsp_valid  (data_rsp_valid),
        .rsp             (rsp)
    );

    ram word_ram (
        .clock     (clock),
        .rst       (rst),
        .ram_valid (ram_valid),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wstrb (ram_wstrb),
        .ram_rdata (ram_rdata),
        .ram_ready (ram_ready)
    );

    // shared read data, qualified by each port's valid.
    assign fetch_rsp = rsp;
    assign data_rsp  = rsp;

endmodule

`default_nettype wire

/* hdl/ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module ram
    import mem_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        rst,

    input  wire logic        ram_valid,
    input  wire logic [31:0] ram_addr,
    input  wire logic [31:0] ram_wdata,
    input  wire logic [3:0]  ram_wstrb,

    output mem_rsp_t         ram_rdata,
    output logic             ram_ready
);

    logic [31:0] mem_words [`MEM_DEPTH_WORDS];
    logic [`MEM_INDEX_BITS-1:0] index;

    // byte address to word index.
    assign index = ram_addr[`MEM_INDEX_BITS+1:2];

    // ========================================
    // storage
    // ========================================

    always_ff @(posedge clock) begin
        if (ram_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_wstrb[b]) begin
                    mem_words[index][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
            ram_rdata.rdata <= mem_words[index];  // old word, read before write.
        end
    end

    // one cycle after the request.
    always_ff @(posedge clock) begin
        if (rst) begin
            ram_ready <= 1'b0;
        end else begin
            ram_ready <= ram_valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
    import mem_pkg::*;
(
    input  wire logic clock,
    input  wire logic rst,

    // fetch buffer.
    input  wire logic       fetch_full,
    input  wire fetch_req_t fetch_req,
    output logic            fetch_pop,

    // data buffer.
    input  wire logic      data_full,
    input  wire data_req_t data_req,
    output logic           data_pop,

    // RAM request.
    output logic        ram_valid,
    output logic [31:0] ram_addr,
    output logic [31:0] ram_wdata,
    output logic [3:0]  ram_wstrb,

    // RAM response.
    input  wire logic     ram_ready,
    input  wire mem_rsp_t ram_rdata,

    // responses to the ports.
    output logic     fetch_rsp_valid,
    output logic     data_rsp_valid,
    output mem_rsp_t rsp
);

    logic      busy;
    logic      issue;
    port_sel_t grant;
    port_sel_t owner;
    port_sel_t last_winner;

    // ========================================
    // grant selection
    // ========================================

    always_comb begin
        if (fetch_full && data_full) begin
            grant = (last_winner == fetch_port) ? data_port : fetch_port;
        end else if (data_full) begin
            grant = data_port;
        end else begin
            grant = fetch_port;
        end
    end

    assign issue = !busy && (fetch_full || data_full);  // one access at a time.

    always_ff @(posedge clock) begin
        if (rst) begin
            ram_valid   <= 1'b0;
            busy        <= 1'b0;
            owner       <= fetch_port;
            last_winner <= fetch_port;  // next tie goes to data.
        end else begin
            ram_valid <= issue;
            if (issue) begin
                busy        <= 1'b1;
                owner       <= grant;
                last_winner <= grant;
            end else if (ram_ready) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            if (grant == data_port) begin
                ram_addr  <= data_req.addr;
                ram_wdata <= data_req.wdata;
                ram_wstrb <= data_req.wstrb;
            end else begin
                ram_addr  <= fetch_req.addr;
                ram_wdata <= '0;
                ram_wstrb <= '0;  // fetch never writes.
            end
        end
    end

    // ========================================
    // response steering
    // ========================================

    assign fetch_rsp_valid = ram_ready && (owner == fetch_port);
    assign data_rsp_valid  = ram_ready && (owner == data_port);
    assign fetch_pop       = fetch_rsp_valid;
    assign data_pop        = data_rsp_valid;
    assign rsp             = ram_rdata;

endmodule

`default_nettype wire

/* hdl/request_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// one-entry request holding stage in front of the arbiter.
module request_buffer
    import mem_pkg::*;
#(
    parameter type payload_t = fetch_req_t
) (
    input  wire logic clock,
    input  wire logic rst,

    // requester side.
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_payload,

    // arbiter side.
    output logic     full,
    output payload_t payload,
    input  wire logic pop
);

    logic accept;

    assign in_ready = !full;
    assign accept   = in_valid && in_ready;

    // stays full until the response goes back.
    always_ff @(posedge clock) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            payload <= in_payload;  // held while full.
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ========================================
    // requests
    // ========================================

    // instruction fetch, always a full word read.
    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    // load or store from the data side.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;  // all zero means read.
    } data_req_t;

    // ========================================
    // responses
    // ========================================

    // word before the access, also for writes.
    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

    // owner of the RAM access.
    typedef enum logic {
        fetch_port = 1'b0,
        data_port  = 1'b1
    } port_sel_t;

endpackage

`default_nettype wire

/* hdl/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ========================================
// RAM geometry
// ========================================

// 32-bit words held by the RAM.
`define MEM_DEPTH_WORDS 256

// word index width, log2 of the depth.
`define MEM_INDEX_BITS 8

`endif
